// ==== rtl/jsp_pkg.sv ====
// JTAG serial port shared types, register offsets and FSM encodings
`default_nettype none

package jsp_pkg;

  ////////////////////////////////////////
  // Data widths

  // One byte on the bus or the JTAG side
  typedef logic [7:0] byte_t;
  // Fill or free count of a FIFO, 0 to 8
  typedef logic [3:0] count_t;
  // 16550 style register offset
  typedef logic [2:0] reg_addr_t;

  localparam int FIFO_DEPTH = 8;

  ////////////////////////////////////////
  // Register map

  localparam reg_addr_t ADDR_DATA    = 3'd0;
  localparam reg_addr_t ADDR_IER     = 3'd1;
  localparam reg_addr_t ADDR_IIR_FCR = 3'd2;
  localparam reg_addr_t ADDR_LCR     = 3'd3;
  localparam reg_addr_t ADDR_MCR     = 3'd4;
  localparam reg_addr_t ADDR_LSR     = 3'd5;
  localparam reg_addr_t ADDR_MSR     = 3'd6;
  localparam reg_addr_t ADDR_SCR     = 3'd7;

  // Fixed modem status, no modem lines
  localparam byte_t MSR_VALUE = 8'h0B;

  // Interrupt identification codes
  localparam byte_t IIR_NONE = 8'h01;
  localparam byte_t IIR_THRE = 8'h02;
  localparam byte_t IIR_RDA  = 8'h04;

  ////////////////////////////////////////
  // FSM encodings

  // Transmit side, CPU to JTAG
  typedef enum logic [1:0] {
    RD_IDLE  = 2'b11,
    RD_PUSH  = 2'b10,
    RD_POP   = 2'b01,
    RD_LATCH = 2'b00
  } rd_state_e;

  // Receive side, JTAG to CPU
  typedef enum logic [1:0] {
    WR_IDLE = 2'b10,
    WR_PUSH = 2'b01,
    WR_POP  = 2'b00
  } wr_state_e;

endpackage

`default_nettype wire

// ==== rtl/jsp_fifo_if.sv ====
// Control, data and fill counts of one byte FIFO
`timescale 1ns/1ns
`default_nettype none

interface jsp_fifo_if;
  import jsp_pkg::*;

  // Request side
  byte_t  wdata;
  logic   push_pop_n;
  logic   en;

  // FIFO side
  byte_t  rdata;
  count_t bytes_avail;
  count_t bytes_free;

  // Bus unit issues push or pop requests
  modport ctrl (
    output wdata,
    output push_pop_n,
    output en,
    input  rdata,
    input  bytes_avail,
    input  bytes_free
  );

  // FIFO storage answers them
  modport fifo (
    input  wdata,
    input  push_pop_n,
    input  en,
    output rdata,
    output bytes_avail,
    output bytes_free
  );

endinterface

`default_nettype wire

// ==== rtl/jsp_bytefifo.sv ====
// Eight entry byte FIFO with single push/pop control and fill counts
`timescale 1ns/1ns
`default_nettype none

module jsp_bytefifo (
  input wire  PCLK,
  input wire  rst_i,
  jsp_fifo_if.fifo f
);
  import jsp_pkg::*;

  // Storage
  byte_t  mem_q [FIFO_DEPTH];

  // Pointers wrap naturally at depth 8
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  count_t cnt_q;

  logic do_push;
  logic do_pop;

  // Push when full or pop when empty is dropped
  assign do_push = f.en & f.push_pop_n & (cnt_q != count_t'(FIFO_DEPTH));
  assign do_pop  = f.en & ~f.push_pop_n & (cnt_q != '0);

  // Pointer and count update
  always_ff @(posedge PCLK or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (do_push) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      cnt_q    <= cnt_q + 1'b1;
    end else if (do_pop) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q    <= cnt_q - 1'b1;
    end
  end

  // Write port
  always_ff @(posedge PCLK) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= f.wdata;
    end
  end

  // Head entry always visible
  assign f.rdata       = mem_q[rd_ptr_q];
  assign f.bytes_avail = cnt_q;
  assign f.bytes_free  = count_t'(FIFO_DEPTH) - cnt_q;

endmodule

`default_nettype wire

// ==== rtl/jsp_strobe_sync.sv ====
// TCK strobe to sticky PCLK flag through a toggle and two flop synchronizer
`timescale 1ns/1ns
`default_nettype none

module jsp_strobe_sync (
  input wire   tck_i,
  input wire   rst_i,
  input wire   strobe_i,
  input wire   PCLK,
  input wire   PRESETn,
  input wire   clear_i,
  output logic flag_o
);

  logic       tgl_q;
  // Two sync stages plus one for edge detect
  logic [2:0] sync_q;
  logic       tgl_edge;

  ////////////////////////////////////////
  // TCK domain

  // One flip per strobe
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      tgl_q <= 1'b0;
    end else if (strobe_i) begin
      tgl_q <= ~tgl_q;
    end
  end

  ////////////////////////////////////////
  // PCLK domain

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[1:0], tgl_q};
    end
  end

  // Any change of the toggle is one strobe
  assign tgl_edge = sync_q[2] ^ sync_q[1];

  // Set wins over clear so a new strobe is kept
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      flag_o <= 1'b0;
    end else if (tgl_edge) begin
      flag_o <= 1'b1;
    end else if (clear_i) begin
      flag_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_count_sync.sv ====
// Carries a FIFO count from PCLK to TCK with a request/acknowledge toggle pair
`timescale 1ns/1ns
`default_nettype none

module jsp_count_sync (
  input wire                   PCLK,
  input wire                   PRESETn,
  input wire                   tck_i,
  input wire                   rst_i,
  input wire  jsp_pkg::count_t count_i,
  output jsp_pkg::count_t      count_o
);
  import jsp_pkg::*;

  // Held stable while the TCK side samples it
  count_t     hold_q;
  logic       req_q;
  logic [1:0] ack_sync_q;
  logic       idle;

  logic [1:0] req_sync_q;
  logic       ack_q;

  ////////////////////////////////////////
  // PCLK side

  // Previous transfer acknowledged
  assign idle = (ack_sync_q[1] == req_q);

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[0], ack_q};
      if (idle) begin
        req_q <= ~req_q;
      end
    end
  end

  // Capture only on a new request
  always_ff @(posedge PCLK) begin
    if (idle) begin
      hold_q <= count_i;
    end
  end

  ////////////////////////////////////////
  // TCK side

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      req_sync_q <= '0;
      ack_q      <= 1'b0;
      count_o    <= '0;
    end else begin
      req_sync_q <= {req_sync_q[0], req_q};
      // New request seen and hold_q settled by now
      if (req_sync_q[1] != ack_q) begin
        count_o <= hold_q;
        ack_q   <= req_sync_q[1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_biu_apb4.sv ====
// APB4 bus unit with 16550 style registers, FIFO control FSMs and interrupt
`timescale 1ns/1ns
`default_nettype none

module jsp_biu_apb4 (
  // JTAG side
  input wire                      tck_i,
  input wire                      rst_i,
  input wire                      wr_strobe_i,
  input wire  jsp_pkg::byte_t     data_i,
  output jsp_pkg::byte_t          data_o,
  // APB4 slave
  input wire                      PCLK,
  input wire                      PRESETn,
  input wire                      PSEL_i,
  input wire                      PENABLE_i,
  input wire                      PWRITE_i,
  input wire  jsp_pkg::reg_addr_t PADDR_i,
  input wire  jsp_pkg::byte_t     PWDATA_i,
  output jsp_pkg::byte_t          PRDATA_o,
  output logic                    PREADY_o,
  output logic                    PSLVERR_o,
  output logic                    int_o,
  // Synchronized strobes
  input wire                      wdata_avail_i,
  output logic                    wda_clear_o,
  input wire                      pop_req_i,
  output logic                    pop_clear_o,
  // FIFO clears and control
  output logic                    rx_fifo_rst_o,
  output logic                    tx_fifo_rst_o,
  jsp_fifo_if.ctrl                rx,
  jsp_fifo_if.ctrl                tx
);
  import jsp_pkg::*;

  byte_t      wr_data_q;
  wr_state_e  wr_state_q;
  wr_state_e  wr_next;
  rd_state_e  rd_state_q;
  rd_state_e  rd_next;

  logic [3:0] ier_q;
  byte_t      lcr_q;
  byte_t      scr_q;
  byte_t      iir;
  byte_t      lsr;
  logic       rx_clr_q;
  logic       tx_clr_q;
  logic       thre_arm_q;

  logic       fifo_sel;
  logic       fifo_rd;
  logic       fifo_wr;
  logic       reg_wr;
  logic       iir_rd;
  logic       rx_not_empty;
  logic       tx_not_full;
  logic       tx_empty;
  logic       tx_pop;
  logic       thre_active;

  ////////////////////////////////////////
  // TCK domain write data

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_data_q <= '0;
    end else if (wr_strobe_i) begin
      wr_data_q <= data_i;
    end
  end

  assign rx.wdata = wr_data_q;
  assign tx.wdata = PWDATA_i;

  ////////////////////////////////////////
  // APB decode

  assign fifo_sel = PSEL_i & (PADDR_i == ADDR_DATA) & ~lcr_q[7];
  // Held from setup phase until PREADY
  assign fifo_rd  = fifo_sel & ~PWRITE_i & ~PREADY_o;
  assign fifo_wr  = fifo_sel &  PWRITE_i & ~PREADY_o;
  assign reg_wr   = PSEL_i & PENABLE_i & PWRITE_i & PREADY_o;
  assign iir_rd   = PSEL_i & PENABLE_i & ~PWRITE_i & PREADY_o & (PADDR_i == ADDR_IIR_FCR);

  assign rx_not_empty = (rx.bytes_avail != '0);
  assign tx_not_full  = (tx.bytes_free != '0);
  assign tx_empty     = (tx.bytes_avail == '0);
  // JTAG read pending and something to give
  assign tx_pop       = pop_req_i & ~tx_empty;

  ////////////////////////////////////////
  // Receive FSM, JTAG pushes and CPU pops

  always_comb begin
    wr_next = WR_IDLE;
    case (wr_state_q)
      WR_IDLE: begin
        if (fifo_rd) begin
          wr_next = WR_POP;
        end else if (wdata_avail_i) begin
          wr_next = WR_PUSH;
        end
      end
      WR_PUSH: if (fifo_rd) wr_next = WR_POP;
      WR_POP:  if (wdata_avail_i) wr_next = WR_PUSH;
      default: wr_next = WR_IDLE;
    endcase
  end

  always_comb begin
    wda_clear_o   = 1'b0;
    rx.push_pop_n = 1'b0;
    rx.en         = 1'b0;
    case (wr_state_q)
      WR_PUSH: begin
        wda_clear_o   = 1'b1;
        rx.push_pop_n = 1'b1;
        rx.en         = 1'b1;
      end
      // Head is on PRDATA this cycle, gone after it
      WR_POP:  rx.en = 1'b1;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Transmit FSM, CPU pushes and JTAG pops

  always_comb begin
    rd_next = RD_IDLE;
    case (rd_state_q)
      RD_IDLE, RD_LATCH: begin
        if (fifo_wr) begin
          rd_next = RD_PUSH;
        end else if (tx_pop) begin
          rd_next = RD_POP;
        end
      end
      RD_PUSH: begin
        // First byte into an empty FIFO goes straight to data_o
        if (tx_empty) begin
          rd_next = RD_LATCH;
        end else if (tx_pop) begin
          rd_next = RD_POP;
        end
      end
      RD_POP:  rd_next = RD_LATCH;
      default: rd_next = RD_IDLE;
    endcase
  end

  always_comb begin
    pop_clear_o   = 1'b0;
    tx.push_pop_n = 1'b0;
    tx.en         = 1'b0;
    case (rd_state_q)
      RD_PUSH: begin
        tx.push_pop_n = 1'b1;
        tx.en         = 1'b1;
      end
      RD_POP: begin
        pop_clear_o = 1'b1;
        tx.en       = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
      PREADY_o   <= 1'b0;
    end else begin
      wr_state_q <= wr_next;
      rd_state_q <= rd_next;
      // Register access acks in the first access cycle
      // FIFO access acks in the cycle its FSM serves it
      PREADY_o   <= (PSEL_i & ~PENABLE_i & (lcr_q[7] | (PADDR_i != ADDR_DATA)))
                    | (wr_next == WR_POP) | (rd_next == RD_PUSH);
    end
  end

  // New head for JTAG
  always_ff @(posedge PCLK) begin
    if (rd_state_q == RD_LATCH) begin
      data_o <= tx.rdata;
    end
  end

  ////////////////////////////////////////
  // Registers

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier_q    <= '0;
      lcr_q    <= '0;
      scr_q    <= '0;
      rx_clr_q <= 1'b0;
      tx_clr_q <= 1'b0;
    end else begin
      // FCR bits 1 and 2, one cycle clear pulses
      rx_clr_q <= reg_wr & (PADDR_i == ADDR_IIR_FCR) & PWDATA_i[1];
      tx_clr_q <= reg_wr & (PADDR_i == ADDR_IIR_FCR) & PWDATA_i[2];
      if (reg_wr) begin
        case (PADDR_i)
          ADDR_IER: if (!lcr_q[7]) ier_q <= PWDATA_i[3:0];
          ADDR_LCR: lcr_q <= PWDATA_i;
          ADDR_SCR: scr_q <= PWDATA_i;
          default: ;
        endcase
      end
    end
  end

  assign rx_fifo_rst_o = rst_i | rx_clr_q;
  assign tx_fifo_rst_o = rst_i | tx_clr_q;

  // THRE armed by a push or by the last pop
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thre_arm_q <= 1'b0;
    end else if ((rd_state_q == RD_PUSH) |
                 ((rd_state_q == RD_POP) & (tx.bytes_avail == count_t'(1)))) begin
      thre_arm_q <= 1'b1;
    end else if (iir_rd & ~rx_not_empty) begin
      thre_arm_q <= 1'b0;
    end
  end

  assign thre_active = thre_arm_q & tx_not_full;

  // RDA before THRE
  always_comb begin
    if (rx_not_empty) begin
      iir = IIR_RDA;
    end else if (thre_active) begin
      iir = IIR_THRE;
    end else begin
      iir = IIR_NONE;
    end
  end

  assign lsr = {1'b0, tx_not_full, tx_not_full, 4'h0, rx_not_empty};

  always_comb begin
    case (PADDR_i)
      ADDR_DATA:    PRDATA_o = rx.rdata;
      ADDR_IER:     PRDATA_o = {4'h0, ier_q};
      ADDR_IIR_FCR: PRDATA_o = iir;
      ADDR_LCR:     PRDATA_o = lcr_q;
      ADDR_MCR:     PRDATA_o = 8'h00;
      ADDR_LSR:     PRDATA_o = lsr;
      ADDR_MSR:     PRDATA_o = MSR_VALUE;
      ADDR_SCR:     PRDATA_o = scr_q;
      default:      PRDATA_o = 8'h00;
    endcase
  end

  assign PSLVERR_o = 1'b0;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      int_o <= 1'b0;
    end else begin
      int_o <= (rx_not_empty & ier_q[0]) | (thre_active & ier_q[1]);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_apb4_top.sv ====
// JTAG serial port with APB4 slave, byte FIFOs and clock domain crossings
`timescale 1ns/1ns
`default_nettype none

module jsp_apb4_top (
  // APB4 slave
  input wire                      PCLK,
  input wire                      PRESETn,
  input wire                      PSEL_i,
  input wire                      PENABLE_i,
  input wire                      PWRITE_i,
  input wire  jsp_pkg::reg_addr_t PADDR_i,
  input wire  jsp_pkg::byte_t     PWDATA_i,
  output wire jsp_pkg::byte_t     PRDATA_o,
  output wire                     PREADY_o,
  output wire                     PSLVERR_o,
  // JTAG side
  input wire                      tck_i,
  input wire                      rst_i,
  input wire  jsp_pkg::byte_t     data_i,
  output wire jsp_pkg::byte_t     data_o,
  output wire jsp_pkg::count_t    bytes_available_o,
  output wire jsp_pkg::count_t    bytes_free_o,
  input wire                      rd_strobe_i,
  input wire                      wr_strobe_i,
  output wire                     int_o
);

  wire wdata_avail;
  wire wda_clear;
  wire pop_req;
  wire pop_clear;
  wire rx_fifo_rst;
  wire tx_fifo_rst;

  // JTAG to CPU and CPU to JTAG
  jsp_fifo_if rx_if ();
  jsp_fifo_if tx_if ();

  jsp_biu_apb4 u_biu (
    .tck_i         (tck_i),
    .rst_i         (rst_i),
    .wr_strobe_i   (wr_strobe_i),
    .data_i        (data_i),
    .data_o        (data_o),
    .PCLK          (PCLK),
    .PRESETn       (PRESETn),
    .PSEL_i        (PSEL_i),
    .PENABLE_i     (PENABLE_i),
    .PWRITE_i      (PWRITE_i),
    .PADDR_i       (PADDR_i),
    .PWDATA_i      (PWDATA_i),
    .PRDATA_o      (PRDATA_o),
    .PREADY_o      (PREADY_o),
    .PSLVERR_o     (PSLVERR_o),
    .int_o         (int_o),
    .wdata_avail_i (wdata_avail),
    .wda_clear_o   (wda_clear),
    .pop_req_i     (pop_req),
    .pop_clear_o   (pop_clear),
    .rx_fifo_rst_o (rx_fifo_rst),
    .tx_fifo_rst_o (tx_fifo_rst),
    .rx            (rx_if.ctrl),
    .tx            (tx_if.ctrl)
  );

  jsp_bytefifo u_rx_fifo (.PCLK(PCLK), .rst_i(rx_fifo_rst), .f(rx_if.fifo));
  jsp_bytefifo u_tx_fifo (.PCLK(PCLK), .rst_i(tx_fifo_rst), .f(tx_if.fifo));

  ////////////////////////////////////////
  // TCK to PCLK strobes

  jsp_strobe_sync u_wr_sync (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .strobe_i (wr_strobe_i),
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .clear_i  (wda_clear),
    .flag_o   (wdata_avail)
  );

  jsp_strobe_sync u_rd_sync (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .strobe_i (rd_strobe_i),
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .clear_i  (pop_clear),
    .flag_o   (pop_req)
  );

  ////////////////////////////////////////
  // PCLK to TCK counts

  // Room left for JTAG writes
  jsp_count_sync u_free_sync (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .count_i (rx_if.bytes_free),
    .count_o (bytes_free_o)
  );

  // Bytes waiting for JTAG reads
  jsp_count_sync u_avail_sync (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .count_i (tx_if.bytes_avail),
    .count_o (bytes_available_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_jsp_apb4_top.sv ====
// Testbench for the JTAG serial port, APB and JTAG drivers with FIFO models
`timescale 1ns/1ns
`default_nettype none

module tb_jsp_apb4_top;
  import jsp_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  // APB and JTAG operations in the whole run rounded up
  localparam int TEST_COUNT = 220;

  logic      PCLK;
  logic      PRESETn;
  logic      PSEL_i;
  logic      PENABLE_i;
  logic      PWRITE_i;
  reg_addr_t PADDR_i;
  byte_t     PWDATA_i;
  byte_t     PRDATA_o;
  wire       PREADY_o;
  wire       PSLVERR_o;
  logic      tck_i;
  logic      rst_i;
  byte_t     data_i;
  byte_t     data_o;
  count_t    bytes_available_o;
  count_t    bytes_free_o;
  logic      rd_strobe_i;
  logic      wr_strobe_i;
  wire       int_o;

  // Reference models
  byte_t      rx_q[$];
  byte_t      tx_q[$];
  logic       thre_m;
  logic [3:0] ier_m;
  byte_t      lcr_m;
  integer     seed;

  jsp_apb4_top dut (
    .PCLK              (PCLK),
    .PRESETn           (PRESETn),
    .PSEL_i            (PSEL_i),
    .PENABLE_i         (PENABLE_i),
    .PWRITE_i          (PWRITE_i),
    .PADDR_i           (PADDR_i),
    .PWDATA_i          (PWDATA_i),
    .PRDATA_o          (PRDATA_o),
    .PREADY_o          (PREADY_o),
    .PSLVERR_o         (PSLVERR_o),
    .tck_i             (tck_i),
    .rst_i             (rst_i),
    .data_i            (data_i),
    .data_o            (data_o),
    .bytes_available_o (bytes_available_o),
    .bytes_free_o      (bytes_free_o),
    .rd_strobe_i       (rd_strobe_i),
    .wr_strobe_i       (wr_strobe_i),
    .int_o             (int_o)
  );

  ////////////////////////////////////////
  // Clocks and watchdog

  initial begin
    PCLK = 1'b0;
    forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
  end

  // Unrelated JTAG clock offset so edges never meet PCLK edges
  initial begin
    tck_i = 1'b0;
    #7;
    forever #30 tck_i = ~tck_i;
  end

  initial begin
    #(RESET_CYCLES * CLK_PERIOD + TEST_COUNT * 200 * CLK_PERIOD);
    $display("Watchdog expired before all tests completed");
    report_failure();
  end

  task automatic report_failure;
    $display("Something failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // Bus protocol checks

  a_no_slverr : assert property (@(posedge PCLK) disable iff (!PRESETn) !PSLVERR_o)
    else begin
      $display("FAIL PSLVERR_o expected 0 got %h", PSLVERR_o);
      report_failure();
    end

  // Register offsets answer in the first access cycle
  a_reg_no_wait : assert property (@(posedge PCLK) disable iff (!PRESETn)
      (PSEL_i && !PENABLE_i && (PADDR_i != ADDR_DATA || lcr_m[7])) |=> PREADY_o)
    else begin
      $display("Register access at offset %0d had a wait state", PADDR_i);
      report_failure();
    end

  ////////////////////////////////////////
  // Model helpers

  function automatic byte_t rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic byte_t lsr_exp();
    logic room;
    room = (tx_q.size() < FIFO_DEPTH);
    return {1'b0, room, room, 4'h0, rx_q.size() != 0};
  endfunction

  // Received data outranks transmit empty
  function automatic byte_t iir_exp();
    if (rx_q.size() != 0) return 8'h04;
    else if (thre_m && tx_q.size() < FIFO_DEPTH) return 8'h02;
    else return 8'h01;
  endfunction

  function automatic logic int_exp();
    return (rx_q.size() != 0 && ier_m[0]) ||
           (thre_m && tx_q.size() < FIFO_DEPTH && ier_m[1]);
  endfunction

  task automatic compare_byte(input string name, input byte_t exp, input byte_t got);
    assert (got === exp) else begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      report_failure();
    end
  endtask

  ////////////////////////////////////////
  // Drivers

  task automatic apb_xfer(input logic wr, input reg_addr_t addr, input byte_t wdata,
                          output byte_t rdata);
    int waits;
    waits = 0;
    @(posedge PCLK);
    #5;
    PSEL_i    = 1'b1;
    PENABLE_i = 1'b0;
    PWRITE_i  = wr;
    PADDR_i   = addr;
    PWDATA_i  = wdata;
    @(posedge PCLK);
    #5;
    PENABLE_i = 1'b1;
    while (!PREADY_o && waits < 50) begin
      @(posedge PCLK);
      #5;
      waits++;
    end
    if (!PREADY_o) begin
      $display("APB access at offset %0d never got PREADY", addr);
      report_failure();
    end else begin
      rdata = PRDATA_o;
      @(posedge PCLK);
      #5;
      PSEL_i    = 1'b0;
      PENABLE_i = 1'b0;
      PWRITE_i  = 1'b0;
    end
  endtask

  task automatic apb_write(input reg_addr_t addr, input byte_t wdata);
    byte_t unused;
    apb_xfer(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input reg_addr_t addr, output byte_t rdata);
    apb_xfer(1'b0, addr, 8'h00, rdata);
  endtask

  task automatic expect_reg(input string name, input reg_addr_t addr, input byte_t exp);
    byte_t got;
    apb_read(addr, got);
    compare_byte(name, exp, got);
  endtask

  // LSR then IIR since an IIR read on empty rx disarms THRE
  task automatic status_check;
    byte_t got;
    apb_read(ADDR_LSR, got);
    compare_byte("LSR", lsr_exp(), got);
    apb_read(ADDR_IIR_FCR, got);
    compare_byte("IIR", iir_exp(), got);
    if (rx_q.size() == 0) thre_m = 1'b0;
  endtask

  task automatic jtag_write(input byte_t b);
    @(posedge tck_i);
    #5;
    data_i      = b;
    wr_strobe_i = 1'b1;
    @(posedge tck_i);
    #5;
    wr_strobe_i = 1'b0;
  endtask

  // Counts come back through the TCK handshake
  task automatic await_count(input logic free_side, input int exp);
    int     n;
    count_t val;
    n = 0;
    @(posedge PCLK);
    #5;
    val = free_side ? bytes_free_o : bytes_available_o;
    while (val != count_t'(exp) && n < 100) begin
      @(posedge PCLK);
      #5;
      n++;
      val = free_side ? bytes_free_o : bytes_available_o;
    end
    compare_byte(free_side ? "bytes_free_o" : "bytes_available_o", byte_t'(exp), {4'h0, val});
  endtask

  task automatic await_int;
    int n;
    n = 0;
    while (int_o !== int_exp() && n < 20) begin
      @(posedge PCLK);
      #5;
      n++;
    end
    compare_byte("int_o", {7'h0, int_exp()}, {7'h0, int_o});
  endtask

  // Pop the head on the JTAG side and expect the next head on data_o
  task automatic jtag_read_check;
    byte_t b;
    @(posedge tck_i);
    #5;
    rd_strobe_i = 1'b1;
    @(posedge tck_i);
    #5;
    rd_strobe_i = 1'b0;
    b = tx_q.pop_front();
    if (tx_q.size() == 0) thre_m = 1'b1;
    repeat (10) @(posedge PCLK);
    #5;
    if (tx_q.size() > 0) compare_byte("data_o", tx_q[0], data_o);
    await_count(1'b0, tx_q.size());
  endtask

  ////////////////////////////////////////
  // Test sequences

  task automatic reg_file_checks;
    byte_t v;
    byte_t ier_v;
    byte_t got;
    expect_reg("IER", ADDR_IER, 8'h00);
    expect_reg("LCR", ADDR_LCR, 8'h00);
    expect_reg("SCR", ADDR_SCR, 8'h00);
    expect_reg("MCR", ADDR_MCR, 8'h00);
    expect_reg("MSR", ADDR_MSR, 8'h0B);
    expect_reg("IIR", ADDR_IIR_FCR, 8'h01);
    await_count(1'b1, FIFO_DEPTH);
    await_count(1'b0, 0);
    v = rand_byte();
    ier_v = {4'h0, v[3:0]};
    apb_write(ADDR_IER, ier_v);
    expect_reg("IER", ADDR_IER, ier_v);
    v = rand_byte();
    apb_write(ADDR_LCR, {1'b0, v[6:0]});
    expect_reg("LCR", ADDR_LCR, {1'b0, v[6:0]});
    v = rand_byte();
    apb_write(ADDR_SCR, v);
    expect_reg("SCR", ADDR_SCR, v);
    // Divisor latch access blocks IER and FIFO
    apb_write(ADDR_LCR, 8'h80);
    lcr_m = 8'h80;
    apb_write(ADDR_IER, ~ier_v);
    expect_reg("IER", ADDR_IER, ier_v);
    apb_write(ADDR_DATA, rand_byte());
    status_check();
    // Blocked read leaves the waiting byte in place
    v = rand_byte();
    jtag_write(v);
    rx_q.push_back(v);
    await_count(1'b1, FIFO_DEPTH - 1);
    apb_read(ADDR_DATA, got);
    status_check();
    apb_write(ADDR_LCR, 8'h00);
    lcr_m = 8'h00;
    expect_reg("LCR", ADDR_LCR, 8'h00);
    apb_read(ADDR_DATA, got);
    v = rx_q.pop_front();
    compare_byte("PRDATA_o", v, got);
    await_count(1'b1, FIFO_DEPTH);
    apb_write(ADDR_IER, 8'h00);
    expect_reg("IER", ADDR_IER, 8'h00);
  endtask

  task automatic jtag_to_cpu;
    byte_t b;
    byte_t got;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      b = rand_byte();
      jtag_write(b);
      rx_q.push_back(b);
      await_count(1'b1, FIFO_DEPTH - rx_q.size());
      status_check();
    end
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      apb_read(ADDR_DATA, got);
      b = rx_q.pop_front();
      compare_byte("PRDATA_o", b, got);
      await_count(1'b1, FIFO_DEPTH - rx_q.size());
      status_check();
    end
  endtask

  task automatic cpu_to_jtag;
    byte_t b;
    // Ninth write hits a full FIFO and is dropped
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      b = rand_byte();
      apb_write(ADDR_DATA, b);
      if (tx_q.size() < FIFO_DEPTH) tx_q.push_back(b);
      thre_m = 1'b1;
      status_check();
    end
    await_count(1'b0, tx_q.size());
    compare_byte("data_o", tx_q[0], data_o);
    while (tx_q.size() > 0) begin
      jtag_read_check();
      status_check();
    end
  endtask

  task automatic fifo_clear_checks;
    byte_t b;
    for (int i = 0; i < 3; i++) begin
      b = rand_byte();
      jtag_write(b);
      rx_q.push_back(b);
      await_count(1'b1, FIFO_DEPTH - rx_q.size());
      b = rand_byte();
      apb_write(ADDR_DATA, b);
      tx_q.push_back(b);
      thre_m = 1'b1;
    end
    await_count(1'b0, 3);
    status_check();
    apb_write(ADDR_IIR_FCR, 8'h02);
    rx_q.delete();
    status_check();
    await_count(1'b1, FIFO_DEPTH);
    await_count(1'b0, 3);
    apb_write(ADDR_IIR_FCR, 8'h04);
    tx_q.delete();
    status_check();
    await_count(1'b0, 0);
  endtask

  task automatic interrupt_checks;
    byte_t b;
    byte_t got;
    apb_write(ADDR_IER, 8'h03);
    ier_m = 4'h3;
    status_check();
    await_int();
    // Receive data available
    b = rand_byte();
    jtag_write(b);
    rx_q.push_back(b);
    await_count(1'b1, FIFO_DEPTH - 1);
    await_int();
    status_check();
    apb_read(ADDR_DATA, got);
    b = rx_q.pop_front();
    compare_byte("PRDATA_o", b, got);
    await_int();
    // Writes arm THRE and the IIR read disarms it
    for (int i = 0; i < 2; i++) begin
      b = rand_byte();
      apb_write(ADDR_DATA, b);
      tx_q.push_back(b);
      thre_m = 1'b1;
    end
    await_int();
    status_check();
    await_int();
    // Draining to empty arms it again
    while (tx_q.size() > 0) jtag_read_check();
    await_int();
    status_check();
    await_int();
    expect_reg("IIR", ADDR_IIR_FCR, 8'h01);
    apb_write(ADDR_IER, 8'h00);
    ier_m = 4'h0;
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    seed        = 32'ha2d5_fde5;
    thre_m      = 1'b0;
    ier_m       = 4'h0;
    lcr_m       = 8'h00;
    PRESETn     = 1'b1;
    rst_i       = 1'b0;
    PSEL_i      = 1'b0;
    PENABLE_i   = 1'b0;
    PWRITE_i    = 1'b0;
    PADDR_i     = '0;
    PWDATA_i    = '0;
    data_i      = '0;
    rd_strobe_i = 1'b0;
    wr_strobe_i = 1'b0;
    // Clean reset edges after time zero
    #1;
    PRESETn = 1'b0;
    rst_i   = 1'b1;
    repeat (RESET_CYCLES) @(posedge PCLK);
    #5;
    PRESETn = 1'b1;
    rst_i   = 1'b0;
    reg_file_checks();
    jtag_to_cpu();
    cpu_to_jtag();
    fifo_clear_checks();
    interrupt_checks();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== jsp_apb4_top.f ====
rtl/jsp_pkg.sv
rtl/jsp_fifo_if.sv
rtl/jsp_bytefifo.sv
rtl/jsp_strobe_sync.sv
rtl/jsp_count_sync.sv
rtl/jsp_biu_apb4.sv
rtl/jsp_apb4_top.sv
testbench/tb_jsp_apb4_top.sv

// ==== Bender.yml ====
package:
  name: jsp_apb4

sources:
  - rtl/jsp_pkg.sv
  - rtl/jsp_fifo_if.sv
  - rtl/jsp_bytefifo.sv
  - rtl/jsp_strobe_sync.sv
  - rtl/jsp_count_sync.sv
  - rtl/jsp_biu_apb4.sv
  - rtl/jsp_apb4_top.sv
  - target: test
    files:
      - testbench/tb_jsp_apb4_top.sv
